// File: run.sh
#!/bin/sh
# compile with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_ooo_core -o sim_ooo_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_ooo_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: tb.f
verilog/ooo_pkg.sv
verilog/rename_stage.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/ooo_core.sv
verification/tb_ooo_core.sv

// File: verification/tb_ooo_core.sv
`default_nettype none

module tb_ooo_core;

    localparam int rob_depth = 8;
    localparam int n_random = 40;
    localparam int n_fill = 12;
    // random, chain, fill, branch, store and r0 tests
    localparam int total_instr = n_random + 6 + n_fill + 10 + 3 + 3;
    localparam int watchdog_cycles = total_instr * (ooo_pkg::mul_latency + rob_depth) * 20;

    typedef struct packed {
        logic [2:0]  rd;
        logic [31:0] data;
        logic        writes;
        logic        is_store;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic        flush;
        logic [31:0] redirect;
    } rec_t;

    logic clk;
    logic arst_n;
    logic in_valid;
    logic in_ready;
    ooo_pkg::opcode_e in_op;
    logic [2:0]  in_rd;
    logic [2:0]  in_rs1;
    logic [2:0]  in_rs2;
    logic [31:0] in_imm;
    logic [31:0] in_pc;
    logic        in_pred_taken;
    logic        commit_valid;
    logic        commit_ready;
    logic [2:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_is_store;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        flush;
    logic [31:0] redirect_pc;
    logic        commit_fire;

    // reference model state
    logic [31:0] mregs [8];
    rec_t        exp_q [$];
    rec_t        exp_head;
    logic        exp_valid = 1'b0;
    logic        squash;
    int          inflight = 0;
    int          flush_count = 0;
    logic        acc_pend;
    logic        com_pend;
    logic        flush_pend;
    ooo_pkg::opcode_e cap_op;
    logic [2:0]  cap_rd;
    logic [2:0]  cap_rs1;
    logic [2:0]  cap_rs2;
    logic [31:0] cap_imm;
    logic [31:0] cap_pc;
    logic        cap_pred;

    string       test_name = "reset";
    int          errors = 0;
    int          err_mark;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] rng = 32'hed3f2338;
    logic [31:0] pc_next = 32'h1000;

    ooo_core #(.rob_depth(rob_depth)) i_dut (.*);

    assign commit_fire = commit_valid && commit_ready;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic void value_error(string what, logic [31:0] exp_v, logic [31:0] act_v);
        $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp_v, act_v);
        errors++;
    endfunction

    function automatic void plain_error(string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        errors++;
    endfunction

    // in-order execution of one accepted instruction
    function automatic void model_exec();
        rec_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic taken;
        logic branch;
        a = mregs[cap_rs1];
        b = mregs[cap_rs2];
        r = '0;
        taken = 1'b0;
        branch = cap_op == ooo_pkg::op_beq || cap_op == ooo_pkg::op_bne;
        r.writes = !(branch || cap_op == ooo_pkg::op_sw);
        case (cap_op)
            ooo_pkg::op_add: r.data = a + b;
            ooo_pkg::op_sub: r.data = a - b;
            ooo_pkg::op_and: r.data = a & b;
            ooo_pkg::op_xor: r.data = a ^ b;
            ooo_pkg::op_mul: r.data = a * b;
            ooo_pkg::op_beq: taken = a == b;
            ooo_pkg::op_bne: taken = a != b;
            default: begin
                r.is_store = 1'b1;
                r.addr = a + cap_imm;
                r.sdata = b;
            end
        endcase
        if (branch) begin
            r.flush = taken != cap_pred;
            r.redirect = taken ? cap_pc + cap_imm : cap_pc + 32'd4;
        end
        r.rd = r.writes ? cap_rd : 3'd0;
        if (r.writes && cap_rd != 3'd0) begin
            mregs[cap_rd] = r.data;
        end
        // younger work is dropped until the flush arrives
        if (r.flush) begin
            squash = 1'b1;
        end
        exp_q.push_back(r);
    endfunction

    // handshakes are sampled mid-cycle, state advances on the edge
    always @(negedge clk) begin
        acc_pend = arst_n && in_valid && in_ready;
        com_pend = arst_n && commit_fire;
        flush_pend = arst_n && flush;
        cap_op = in_op;
        cap_rd = in_rd;
        cap_rs1 = in_rs1;
        cap_rs2 = in_rs2;
        cap_imm = in_imm;
        cap_pc = in_pc;
        cap_pred = in_pred_taken;
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_q.delete();
            inflight = 0;
            squash = 1'b0;
            // register i comes out of reset holding i
            for (int i = 0; i < 8; i++) begin
                mregs[i] = 32'(i);
            end
        end else begin
            if (com_pend) begin
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                inflight--;
            end
            if (flush_pend) begin
                squash = 1'b0;
                inflight = 0;
                flush_count++;
            end
            if (acc_pend) begin
                inflight++;
                if (!squash) begin
                    model_exec();
                end
            end
        end
        exp_valid = exp_q.size() > 0;
        if (exp_valid) begin
            exp_head = exp_q[0];
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) commit_fire |-> exp_valid)
        else plain_error("an instruction committed that the model does not expect");
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid |-> commit_rd == exp_head.rd)
        else value_error("commit_rd", 32'($sampled(exp_head.rd)), 32'($sampled(commit_rd)));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid && exp_head.writes |-> commit_data == exp_head.data)
        else value_error("commit_data", $sampled(exp_head.data), $sampled(commit_data));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid |-> commit_is_store == exp_head.is_store)
        else value_error("commit_is_store", 32'($sampled(exp_head.is_store)),
            32'($sampled(commit_is_store)));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid && exp_head.is_store |-> store_addr == exp_head.addr)
        else value_error("store_addr", $sampled(exp_head.addr), $sampled(store_addr));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid && exp_head.is_store |-> store_data == exp_head.sdata)
        else value_error("store_data", $sampled(exp_head.sdata), $sampled(store_data));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid |-> flush == exp_head.flush)
        else value_error("flush", 32'($sampled(exp_head.flush)), 32'($sampled(flush)));
    assert property (@(posedge clk) disable iff (!arst_n)
        commit_fire && exp_valid && exp_head.flush |-> redirect_pc == exp_head.redirect)
        else value_error("redirect_pc", $sampled(exp_head.redirect), $sampled(redirect_pc));
    assert property (@(posedge clk) disable iff (!arst_n) flush |-> commit_fire)
        else plain_error("flush pulsed without a branch retiring");
    assert property (@(posedge clk) disable iff (!arst_n) inflight >= rob_depth |-> !in_ready)
        else plain_error("in_ready stayed high with a full reorder buffer");

    task automatic send(input ooo_pkg::opcode_e op, input logic [2:0] rd, input logic [2:0] rs1,
                        input logic [2:0] rs2, input logic [31:0] imm, input logic pred);
        logic done;
        in_valid = 1'b1;
        in_op = op;
        in_rd = rd;
        in_rs1 = rs1;
        in_rs2 = rs2;
        in_imm = imm;
        in_pc = pc_next;
        in_pred_taken = pred;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0 || inflight != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (errors == err_mark) begin
            pass_count++;
            $display("%s: done, no errors", test_name);
        end else begin
            fail_count++;
            $display("%s: done, %0d errors", test_name, errors - err_mark);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          flush_mark;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_op = ooo_pkg::op_add;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        in_pc = '0;
        in_pred_taken = 1'b0;
        commit_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        start_test("random_alu_mul");
        for (int i = 0; i < n_random; i++) begin
            r = next_rand();
            send(ooo_pkg::opcode_e'(r[31:8] % 5), r[2:0], r[5:3], r[8:6], '0, 1'b0);
        end
        end_test();

        start_test("mul_chain");
        send(ooo_pkg::op_mul, 3'd1, 3'd2, 3'd3, '0, 1'b0);
        send(ooo_pkg::op_add, 3'd2, 3'd1, 3'd1, '0, 1'b0);
        send(ooo_pkg::op_mul, 3'd3, 3'd2, 3'd1, '0, 1'b0);
        send(ooo_pkg::op_add, 3'd4, 3'd3, 3'd3, '0, 1'b0);
        send(ooo_pkg::op_sub, 3'd5, 3'd4, 3'd1, '0, 1'b0);
        send(ooo_pkg::op_and, 3'd6, 3'd5, 3'd3, '0, 1'b0);
        end_test();

        start_test("commit_backpressure");
        commit_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < n_fill; i++) begin
                    send(ooo_pkg::op_add, 3'(i % 7 + 1), 3'd0, 3'd0, '0, 1'b0);
                end
            end
            begin
                while (inflight < rob_depth) begin
                    @(negedge clk);
                end
                repeat (4) @(negedge clk);
                @(posedge clk);
                #1;
                commit_ready = 1'b1;
            end
        join
        end_test();

        start_test("branch_flush");
        flush_mark = flush_count;
        commit_ready = 1'b0;
        // taken beq predicted not taken, with wrong-path work behind it
        send(ooo_pkg::op_beq, 3'd0, 3'd0, 3'd0, 32'h40, 1'b0);
        send(ooo_pkg::op_add, 3'd1, 3'd0, 3'd0, '0, 1'b0);
        send(ooo_pkg::op_add, 3'd2, 3'd0, 3'd0, '0, 1'b0);
        send(ooo_pkg::op_mul, 3'd3, 3'd0, 3'd0, '0, 1'b0);
        commit_ready = 1'b1;
        send(ooo_pkg::op_bne, 3'd0, 3'd0, 3'd0, 32'h20, 1'b0);
        send(ooo_pkg::op_beq, 3'd0, 3'd0, 3'd0, 32'h10, 1'b1);
        send(ooo_pkg::op_bne, 3'd0, 3'd0, 3'd0, 32'h30, 1'b1);
        send(ooo_pkg::op_add, 3'd4, 3'd0, 3'd0, '0, 1'b0);
        send(ooo_pkg::op_xor, 3'd5, 3'd0, 3'd0, '0, 1'b0);
        send(ooo_pkg::op_add, 3'd6, 3'd0, 3'd0, '0, 1'b0);
        end_test();
        if (flush_count - flush_mark != 2) begin
            value_error("flush pulses", 32'd2, 32'(flush_count - flush_mark));
            fail_count++;
        end

        start_test("store_release");
        send(ooo_pkg::op_sw, 3'd0, 3'd2, 3'd3, 32'h100, 1'b0);
        send(ooo_pkg::op_add, 3'd2, 3'd2, 3'd3, '0, 1'b0);
        send(ooo_pkg::op_sw, 3'd0, 3'd2, 3'd4, 32'h7f0, 1'b0);
        end_test();

        start_test("zero_register");
        send(ooo_pkg::op_add, 3'd0, 3'd1, 3'd2, '0, 1'b0);
        send(ooo_pkg::op_mul, 3'd0, 3'd3, 3'd4, '0, 1'b0);
        send(ooo_pkg::op_xor, 3'd7, 3'd0, 3'd0, '0, 1'b0);
        end_test();

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int rob_depth = 8,
    localparam int tag_bits = $clog2(rob_depth)
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             issue_valid,
    input  wire ooo_pkg::opcode_e           issue_op,
    input  wire [tag_bits-1:0]              issue_tag,
    input  wire [ooo_pkg::xlen-1:0]         issue_a,
    input  wire [ooo_pkg::xlen-1:0]         issue_b,
    input  wire [ooo_pkg::xlen-1:0]         issue_imm,
    input  wire [ooo_pkg::pc_bits-1:0]      issue_pc,
    input  wire                             issue_pred_taken,
    input  wire                             flush,
    output logic                            alu_valid,
    output logic [tag_bits-1:0]             alu_tag,
    output logic [ooo_pkg::xlen-1:0]        alu_data,
    output logic                            alu_taken,
    output logic [ooo_pkg::pc_bits-1:0]     alu_target,
    output logic [ooo_pkg::xlen-1:0]        alu_addr,
    output logic                            mul_valid,
    output logic [tag_bits-1:0]             mul_tag,
    output logic [ooo_pkg::xlen-1:0]        mul_data
);

    localparam int lat = ooo_pkg::mul_latency;

    logic [ooo_pkg::xlen-1:0] res;
    logic                     taken;
    logic                     is_mul;
    logic [lat-1:0]           mv_q;
    logic [tag_bits-1:0]      mtag_q [lat];
    logic [ooo_pkg::xlen-1:0] mdata_q [lat];

    assign is_mul = issue_op == ooo_pkg::op_mul;

    always_comb begin
        res = '0;
        taken = 1'b0;
        case (issue_op)
            ooo_pkg::op_add: res = issue_a + issue_b;
            ooo_pkg::op_sub: res = issue_a - issue_b;
            ooo_pkg::op_and: res = issue_a & issue_b;
            ooo_pkg::op_xor: res = issue_a ^ issue_b;
            ooo_pkg::op_beq: taken = issue_a == issue_b;
            ooo_pkg::op_bne: taken = issue_a != issue_b;
            ooo_pkg::op_sw:  res = issue_b;
            default: res = '0;
        endcase
        // branch result word flags a mispredict
        if (issue_op == ooo_pkg::op_beq || issue_op == ooo_pkg::op_bne) begin
            res = {{(ooo_pkg::xlen-1){1'b0}}, taken != issue_pred_taken};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_valid <= 1'b0;
            mv_q <= '0;
        end else if (flush) begin
            alu_valid <= 1'b0;
            mv_q <= '0;
        end else begin
            alu_valid <= issue_valid && !is_mul;
            mv_q <= {mv_q[lat-2:0], issue_valid && is_mul};
        end
    end

    always_ff @(posedge clk) begin
        alu_tag <= issue_tag;
        alu_data <= res;
        alu_taken <= taken;
        alu_target <= taken ? issue_pc + issue_imm : issue_pc + 4;
        alu_addr <= issue_a + issue_imm;
        // product formed up front, then shifted down the pipe
        mtag_q[0] <= issue_tag;
        mdata_q[0] <= issue_a * issue_b;
        for (int i = 1; i < lat; i++) begin
            mtag_q[i] <= mtag_q[i-1];
            mdata_q[i] <= mdata_q[i-1];
        end
    end

    assign mul_valid = mv_q[lat-1];
    assign mul_tag = mtag_q[lat-1];
    assign mul_data = mdata_q[lat-1];

    // tags are unique while in flight
    assert property (@(posedge clk) disable iff (!arst_n)
        !(alu_valid && mul_valid && alu_tag == mul_tag));

endmodule

`default_nettype wire

// File: verilog/ooo_core.sv
`default_nettype none

module ooo_core #(
    parameter int rob_depth = 8,
    localparam int tag_bits = $clog2(rob_depth)
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire ooo_pkg::opcode_e           in_op,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rd,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rs1,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rs2,
    input  wire [ooo_pkg::xlen-1:0]         in_imm,
    input  wire [ooo_pkg::pc_bits-1:0]      in_pc,
    input  wire                             in_pred_taken,
    output logic                            commit_valid,
    input  wire                             commit_ready,
    output logic [ooo_pkg::reg_bits-1:0]    commit_rd,
    output logic [ooo_pkg::xlen-1:0]        commit_data,
    output logic                            commit_is_store,
    output logic [ooo_pkg::xlen-1:0]        store_addr,
    output logic [ooo_pkg::xlen-1:0]        store_data,
    output logic                            flush,
    output logic [ooo_pkg::pc_bits-1:0]     redirect_pc
);

    // allocation and forwarding
    logic                            alloc_valid;
    ooo_pkg::opcode_e                alloc_op;
    logic [ooo_pkg::reg_bits-1:0]    alloc_rd;
    logic [ooo_pkg::pc_bits-1:0]     alloc_pc;
    logic                            alloc_pred_taken;
    logic [tag_bits-1:0]             alloc_tag;
    logic                            rob_full;
    logic [tag_bits-1:0]             fwd_tag_a;
    logic [tag_bits-1:0]             fwd_tag_b;
    logic                            fwd_done_a;
    logic [ooo_pkg::xlen-1:0]        fwd_data_a;
    logic                            fwd_done_b;
    logic [ooo_pkg::xlen-1:0]        fwd_data_b;

    // issue
    logic                            issue_valid;
    ooo_pkg::opcode_e                issue_op;
    logic [tag_bits-1:0]             issue_tag;
    logic [ooo_pkg::xlen-1:0]        issue_a;
    logic [ooo_pkg::xlen-1:0]        issue_b;
    logic [ooo_pkg::xlen-1:0]        issue_imm;
    logic [ooo_pkg::pc_bits-1:0]     issue_pc;
    logic                            issue_pred_taken;

    // completion and retire
    logic                            alu_valid;
    logic [tag_bits-1:0]             alu_tag;
    logic [ooo_pkg::xlen-1:0]        alu_data;
    logic                            alu_taken;
    logic [ooo_pkg::pc_bits-1:0]     alu_target;
    logic [ooo_pkg::xlen-1:0]        alu_addr;
    logic                            mul_valid;
    logic [tag_bits-1:0]             mul_tag;
    logic [ooo_pkg::xlen-1:0]        mul_data;
    logic                            ret_valid;
    logic [ooo_pkg::reg_bits-1:0]    ret_rd;
    logic [ooo_pkg::xlen-1:0]        ret_data;
    logic [tag_bits-1:0]             ret_tag;

    rename_stage #(.rob_depth(rob_depth)) i_rename (.*);

    exec_unit #(.rob_depth(rob_depth)) i_exec (.*);

    rob #(.rob_depth(rob_depth)) i_rob (.*);

endmodule

`default_nettype wire

// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    parameter int xlen = 32;
    parameter int reg_bits = 3;
    parameter int pc_bits = 32;
    parameter int mul_latency = 3;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_beq,
        op_bne,
        op_sw
    } opcode_e;

    // per-entry lifecycle in the reorder buffer
    typedef enum logic [1:0] {
        st_free,
        st_busy,
        st_done
    } entry_state_e;

    // branches and stores leave the register file alone
    function automatic logic writes_reg(opcode_e op);
        return !(op == op_beq || op == op_bne || op == op_sw);
    endfunction

endpackage

`default_nettype wire

// File: verilog/rename_stage.sv
`default_nettype none

module rename_stage #(
    parameter int rob_depth = 8,
    localparam int tag_bits = $clog2(rob_depth)
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire ooo_pkg::opcode_e           in_op,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rd,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rs1,
    input  wire [ooo_pkg::reg_bits-1:0]     in_rs2,
    input  wire [ooo_pkg::xlen-1:0]         in_imm,
    input  wire [ooo_pkg::pc_bits-1:0]      in_pc,
    input  wire                             in_pred_taken,
    output logic                            alloc_valid,
    output ooo_pkg::opcode_e                alloc_op,
    output logic [ooo_pkg::reg_bits-1:0]    alloc_rd,
    output logic [ooo_pkg::pc_bits-1:0]     alloc_pc,
    output logic                            alloc_pred_taken,
    input  wire [tag_bits-1:0]              alloc_tag,
    input  wire                             rob_full,
    output logic [tag_bits-1:0]             fwd_tag_a,
    output logic [tag_bits-1:0]             fwd_tag_b,
    input  wire                             fwd_done_a,
    input  wire [ooo_pkg::xlen-1:0]         fwd_data_a,
    input  wire                             fwd_done_b,
    input  wire [ooo_pkg::xlen-1:0]         fwd_data_b,
    input  wire                             ret_valid,
    input  wire [ooo_pkg::reg_bits-1:0]     ret_rd,
    input  wire [ooo_pkg::xlen-1:0]         ret_data,
    input  wire [tag_bits-1:0]              ret_tag,
    input  wire                             flush,
    output logic                            issue_valid,
    output ooo_pkg::opcode_e                issue_op,
    output logic [tag_bits-1:0]             issue_tag,
    output logic [ooo_pkg::xlen-1:0]        issue_a,
    output logic [ooo_pkg::xlen-1:0]        issue_b,
    output logic [ooo_pkg::xlen-1:0]        issue_imm,
    output logic [ooo_pkg::pc_bits-1:0]     issue_pc,
    output logic                            issue_pred_taken
);

    localparam int num_regs = 1 << ooo_pkg::reg_bits;

    logic [ooo_pkg::xlen-1:0] regs [num_regs];
    logic [num_regs-1:0]      busy_q;
    logic [tag_bits-1:0]      tag_q [num_regs];
    logic                     run_q;
    logic                     stall_a;
    logic                     stall_b;
    logic [ooo_pkg::xlen-1:0] val_a;
    logic [ooo_pkg::xlen-1:0] val_b;
    logic                     fire;

    assign fwd_tag_a = tag_q[in_rs1];
    assign fwd_tag_b = tag_q[in_rs2];

    // busy source: forward if the producer is done, otherwise wait
    always_comb begin
        stall_a = 1'b0;
        stall_b = 1'b0;
        val_a = regs[in_rs1];
        val_b = regs[in_rs2];
        if (busy_q[in_rs1]) begin
            val_a = fwd_data_a;
            stall_a = !fwd_done_a;
        end
        if (busy_q[in_rs2]) begin
            val_b = fwd_data_b;
            stall_b = !fwd_done_b;
        end
    end

    assign in_ready = run_q && !flush && !rob_full && !stall_a && !stall_b;
    assign fire = in_valid && in_ready;

    assign alloc_valid = fire;
    assign alloc_op = in_op;
    assign alloc_rd = in_rd;
    assign alloc_pc = in_pc;
    assign alloc_pred_taken = in_pred_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            busy_q <= '0;
            issue_valid <= 1'b0;
            // register i starts out holding i
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= ooo_pkg::xlen'(i);
            end
        end else begin
            run_q <= 1'b1;
            issue_valid <= fire;
            if (ret_valid && ret_rd != '0) begin
                regs[ret_rd] <= ret_data;
                // a newer writer keeps its claim
                if (tag_q[ret_rd] == ret_tag) begin
                    busy_q[ret_rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy_q <= '0;
            end else if (fire && ooo_pkg::writes_reg(in_op) && in_rd != '0) begin
                busy_q[in_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (ooo_pkg::writes_reg(in_op) && in_rd != '0) begin
                tag_q[in_rd] <= alloc_tag;
            end
            issue_op <= in_op;
            issue_tag <= alloc_tag;
            issue_a <= val_a;
            issue_b <= val_b;
            issue_imm <= in_imm;
            issue_pc <= in_pc;
            issue_pred_taken <= in_pred_taken;
        end
    end

    // nothing accepted in the flush cycle may reach execution
    assert property (@(posedge clk) disable iff (!arst_n) flush |=> !issue_valid);

endmodule

`default_nettype wire

// File: verilog/rob.sv
`default_nettype none

module rob #(
    parameter int rob_depth = 8,
    localparam int tag_bits = $clog2(rob_depth)
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             alloc_valid,
    input  wire ooo_pkg::opcode_e           alloc_op,
    input  wire [ooo_pkg::reg_bits-1:0]     alloc_rd,
    input  wire [ooo_pkg::pc_bits-1:0]      alloc_pc,
    input  wire                             alloc_pred_taken,
    output logic [tag_bits-1:0]             alloc_tag,
    output logic                            rob_full,
    input  wire [tag_bits-1:0]              fwd_tag_a,
    input  wire [tag_bits-1:0]              fwd_tag_b,
    output logic                            fwd_done_a,
    output logic [ooo_pkg::xlen-1:0]        fwd_data_a,
    output logic                            fwd_done_b,
    output logic [ooo_pkg::xlen-1:0]        fwd_data_b,
    input  wire                             alu_valid,
    input  wire [tag_bits-1:0]              alu_tag,
    input  wire [ooo_pkg::xlen-1:0]         alu_data,
    input  wire                             alu_taken,
    input  wire [ooo_pkg::pc_bits-1:0]      alu_target,
    input  wire [ooo_pkg::xlen-1:0]         alu_addr,
    input  wire                             mul_valid,
    input  wire [tag_bits-1:0]              mul_tag,
    input  wire [ooo_pkg::xlen-1:0]         mul_data,
    output logic                            commit_valid,
    input  wire                             commit_ready,
    output logic [ooo_pkg::reg_bits-1:0]    commit_rd,
    output logic [ooo_pkg::xlen-1:0]        commit_data,
    output logic                            commit_is_store,
    output logic [ooo_pkg::xlen-1:0]        store_addr,
    output logic [ooo_pkg::xlen-1:0]        store_data,
    output logic                            ret_valid,
    output logic [ooo_pkg::reg_bits-1:0]    ret_rd,
    output logic [ooo_pkg::xlen-1:0]        ret_data,
    output logic [tag_bits-1:0]             ret_tag,
    output logic                            flush,
    output logic [ooo_pkg::pc_bits-1:0]     redirect_pc
);

    ooo_pkg::entry_state_e           state_q  [rob_depth];
    ooo_pkg::opcode_e                op_q     [rob_depth];
    logic [ooo_pkg::reg_bits-1:0]    rd_q     [rob_depth];
    logic [ooo_pkg::xlen-1:0]        data_q   [rob_depth];
    logic                            pred_q   [rob_depth];
    logic                            taken_q  [rob_depth];
    logic [ooo_pkg::pc_bits-1:0]     target_q [rob_depth];
    logic [ooo_pkg::xlen-1:0]        addr_q   [rob_depth];
    logic [tag_bits-1:0]             head_q;
    logic [tag_bits-1:0]             tail_q;
    logic [tag_bits:0]               count_q;
    logic                            commit_fire;
    logic                            head_branch;

    assign alloc_tag = tail_q;
    assign rob_full = count_q == rob_depth;

    assign fwd_done_a = state_q[fwd_tag_a] == ooo_pkg::st_done;
    assign fwd_data_a = data_q[fwd_tag_a];
    assign fwd_done_b = state_q[fwd_tag_b] == ooo_pkg::st_done;
    assign fwd_data_b = data_q[fwd_tag_b];

    // free entries are never done, so an empty buffer shows no commit
    assign commit_valid = state_q[head_q] == ooo_pkg::st_done;
    assign commit_fire = commit_valid && commit_ready;
    assign head_branch = op_q[head_q] == ooo_pkg::op_beq || op_q[head_q] == ooo_pkg::op_bne;

    assign commit_rd = rd_q[head_q];
    assign commit_data = data_q[head_q];
    assign commit_is_store = op_q[head_q] == ooo_pkg::op_sw;
    assign store_addr = addr_q[head_q];
    assign store_data = data_q[head_q];

    assign ret_valid = commit_fire;
    assign ret_rd = rd_q[head_q];
    assign ret_data = data_q[head_q];
    assign ret_tag = head_q;

    assign flush = commit_fire && head_branch && (taken_q[head_q] != pred_q[head_q]);
    assign redirect_pc = target_q[head_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                state_q[i] <= ooo_pkg::st_free;
            end
        end else if (flush) begin
            // everything behind the branch is wrong path
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                state_q[i] <= ooo_pkg::st_free;
            end
        end else begin
            if (alloc_valid) begin
                state_q[tail_q] <= ooo_pkg::st_busy;
                tail_q <= tail_q + 1'b1;
            end
            if (alu_valid) begin
                state_q[alu_tag] <= ooo_pkg::st_done;
            end
            if (mul_valid) begin
                state_q[mul_tag] <= ooo_pkg::st_done;
            end
            if (commit_fire) begin
                state_q[head_q] <= ooo_pkg::st_free;
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (tag_bits+1)'(alloc_valid) - (tag_bits+1)'(commit_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            op_q[tail_q] <= alloc_op;
            rd_q[tail_q] <= ooo_pkg::writes_reg(alloc_op) ? alloc_rd : '0;
            pred_q[tail_q] <= alloc_pred_taken;
            // fall-through pc until the branch resolves
            target_q[tail_q] <= alloc_pc + 4;
        end
        if (alu_valid) begin
            data_q[alu_tag] <= alu_data;
            taken_q[alu_tag] <= alu_taken;
            target_q[alu_tag] <= alu_target;
            addr_q[alu_tag] <= alu_addr;
        end
        if (mul_valid) begin
            data_q[mul_tag] <= mul_data;
            taken_q[mul_tag] <= 1'b0;
        end
    end

    // a completion must belong to a live entry
    assert property (@(posedge clk) disable iff (!arst_n)
        alu_valid |-> state_q[alu_tag] != ooo_pkg::st_free);
    assert property (@(posedge clk) disable iff (!arst_n)
        mul_valid |-> state_q[mul_tag] != ooo_pkg::st_free);
    assert property (@(posedge clk) disable iff (!arst_n) count_q <= rob_depth);

endmodule

`default_nettype wire
